// ==== src/rename_pkg.sv ====
package rename_pkg;

    localparam int ARCH_REG_SZ = 8;
    localparam int PHYS_REG_SZ = 16;
    localparam int BR_DEPTH    = 4;  // also the width of a branch id / mask
    localparam int ROB_SZ      = 16;

    typedef logic [$clog2(ARCH_REG_SZ)-1:0] arch_idx_t;
    typedef logic [$clog2(PHYS_REG_SZ)-1:0] phys_idx_t;
    typedef logic [$clog2(PHYS_REG_SZ)-1:0] fl_ptr_t;
    typedef logic [$clog2(ROB_SZ)-1:0]      rob_idx_t;
    typedef logic [BR_DEPTH-1:0]            b_id_t;  // one-hot id or dependency mask
    typedef logic [31:0]                    pc_t;

    // command from the branch unit for one resolved branch
    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_CLEAR  = 2'd1,  // predicted correctly
        BR_SQUASH = 2'd2   // mispredicted, roll back
    } br_task_e;

    typedef struct packed {
        phys_idx_t phys;
        logic      ready;
    } map_entry_t;

    // everything needed to roll the front end back to a branch
    typedef struct packed {
        logic                         valid;
        b_id_t                        b_id;
        b_id_t                        b_mask;   // own id plus older live branches
        pc_t                          rec_pc;
        map_entry_t [ARCH_REG_SZ-1:0] rec_mt;
        fl_ptr_t                      fl_head;
        rob_idx_t                     rob_tail;
    } checkpoint_t;

endpackage

// ==== src/free_select.sv ====
`timescale 1ns/10ps

module free_select (
    input  rename_pkg::b_id_t free_mask,
    output rename_pkg::b_id_t grant,
    output logic              none_free
);

    // lowest set bit wins
    always_comb begin
        grant     = free_mask & (~free_mask + 1'b1);
        none_free = (free_mask == '0);

        // grant must be a single free slot, and only absent when nothing is free
        assert ($onehot0(grant) && ((grant & ~free_mask) == '0)
                && (none_free == (grant == '0)));
    end

endmodule

// ==== src/free_list.sv ====
`timescale 1ns/10ps

module free_list (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  pop,           // rename takes the head
    input  logic                  push,          // retire returns a register
    input  rename_pkg::phys_idx_t push_phys,

    input  logic                  restore_valid, // squash
    input  rename_pkg::fl_ptr_t   restore_head,

    output rename_pkg::phys_idx_t head_phys,
    output rename_pkg::fl_ptr_t   head,
    output logic                  empty
);

    import rename_pkg::*;

    phys_idx_t                    mem [PHYS_REG_SZ];
    fl_ptr_t                      tail;
    fl_ptr_t                      tail_next;
    logic [$clog2(PHYS_REG_SZ):0] count;

    assign head_phys = mem[head];
    assign empty     = (count == '0);
    assign tail_next = push ? tail + 1'b1 : tail;

    // slots 0..7 start out holding phys 8..15
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < PHYS_REG_SZ; i++) begin
                mem[i] <= phys_idx_t'(i + ARCH_REG_SZ);
            end
        end else if (push) begin
            mem[tail] <= push_phys;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= fl_ptr_t'(PHYS_REG_SZ - ARCH_REG_SZ);
            count <= ($clog2(PHYS_REG_SZ)+1)'(PHYS_REG_SZ - ARCH_REG_SZ);
        end else begin
            tail <= tail_next;
            if (restore_valid) begin
                // registers popped since the checkpoint become free again
                head  <= restore_head;
                count <= {1'b0, fl_ptr_t'(tail_next - restore_head)};
            end else begin
                if (pop) begin
                    head <= head + 1'b1;
                end
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    // the top must hold off renames once the list runs dry
    assert property (@(posedge clock) disable iff (reset) pop |-> !empty);

    // a squash cycle never renames, so the head is not moved two ways at once
    assert property (@(posedge clock) disable iff (reset) restore_valid |-> !pop);

endmodule

// ==== src/map_table.sv ====
`timescale 1ns/10ps

module map_table (
    input  logic                    clock,
    input  logic                    reset,

    input  logic                    rename_valid,
    input  rename_pkg::arch_idx_t   rename_arch,
    input  rename_pkg::phys_idx_t   rename_phys,

    input  logic                    cdb_valid,
    input  rename_pkg::arch_idx_t   cdb_arch,
    input  rename_pkg::phys_idx_t   cdb_phys,

    input  logic                    restore_valid,
    input  rename_pkg::checkpoint_t restore_cp,

    input  rename_pkg::arch_idx_t   lookup_arch,
    output rename_pkg::phys_idx_t   lookup_phys,
    output logic                    lookup_ready,

    output rename_pkg::map_entry_t [rename_pkg::ARCH_REG_SZ-1:0] mt_out
);

    import rename_pkg::*;

    map_entry_t [ARCH_REG_SZ-1:0] mt;
    map_entry_t [ARCH_REG_SZ-1:0] mt_next;

    assign mt_out       = mt;
    assign lookup_phys  = mt[lookup_arch].phys;
    assign lookup_ready = mt[lookup_arch].ready;

    always_comb begin
        if (restore_valid) begin
            mt_next = restore_cp.rec_mt;  // restore beats rename
        end else begin
            mt_next = mt;
            if (rename_valid) begin
                mt_next[rename_arch].phys  = rename_phys;
                mt_next[rename_arch].ready = 1'b0;
            end
        end

        // wakeup on top of either, so a completion in a squash cycle still lands
        if (cdb_valid && (mt_next[cdb_arch].phys == cdb_phys)) begin
            mt_next[cdb_arch].ready = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REG_SZ; i++) begin
                mt[i].phys  <= phys_idx_t'(i);  // identity map, all ready
                mt[i].ready <= 1'b1;
            end
        end else begin
            mt <= mt_next;
        end
    end

endmodule

// ==== src/br_stack.sv ====
`timescale 1ns/10ps

module br_stack (
    input  logic                    clock,
    input  logic                    reset,

    input  logic                    take_branch,
    input  rename_pkg::pc_t         branch_pc,

    input  rename_pkg::map_entry_t [rename_pkg::ARCH_REG_SZ-1:0] in_mt,
    input  rename_pkg::fl_ptr_t     in_fl_head,
    input  rename_pkg::rob_idx_t    in_rob_tail,

    input  logic                    cdb_valid,
    input  rename_pkg::arch_idx_t   cdb_arch,
    input  rename_pkg::phys_idx_t   cdb_phys,

    input  rename_pkg::br_task_e    br_task,
    input  rename_pkg::b_id_t       rem_b_id,  // id being resolved

    output rename_pkg::b_id_t       assigned_b_id,
    output logic                    full,
    output logic                    restore_valid,
    output rename_pkg::checkpoint_t cp_out
);

    import rename_pkg::*;

    checkpoint_t [BR_DEPTH-1:0] entries;
    checkpoint_t [BR_DEPTH-1:0] next_entries;

    b_id_t free_mask;  // 1 = slot free
    b_id_t grant;
    b_id_t live_ids;
    logic  alloc;

    free_select u_free_select (
        .free_mask (free_mask),
        .grant     (grant),
        .none_free (full)
    );

    always_comb begin
        for (int i = 0; i < BR_DEPTH; i++) begin
            free_mask[i] = !entries[i].valid;
        end
    end

    assign alloc         = take_branch && !full;  // dropped when full
    assign assigned_b_id = alloc ? grant : '0;

    // squash target, kept apart from next state so the top can gate dispatch on it
    always_comb begin
        restore_valid = 1'b0;
        cp_out        = '0;
        if (br_task == BR_SQUASH) begin
            for (int i = 0; i < BR_DEPTH; i++) begin
                if (entries[i].valid && (entries[i].b_id == rem_b_id)) begin
                    restore_valid = 1'b1;
                    cp_out        = entries[i];
                end
            end
        end
    end

    always_comb begin
        next_entries = entries;
        live_ids     = '0;

        case (br_task)
            BR_SQUASH: begin
                // the branch itself and everything younger depend on its bit
                for (int i = 0; i < BR_DEPTH; i++) begin
                    if ((entries[i].b_mask & rem_b_id) != '0) begin
                        next_entries[i] = '0;
                    end
                end
            end
            BR_CLEAR: begin
                for (int i = 0; i < BR_DEPTH; i++) begin
                    if (entries[i].valid && (entries[i].b_id == rem_b_id)) begin
                        next_entries[i] = '0;
                    end else begin
                        next_entries[i].b_mask = entries[i].b_mask & ~rem_b_id;
                    end
                end
            end
            default: ;
        endcase

        // older branches still unresolved after this cycle
        for (int i = 0; i < BR_DEPTH; i++) begin
            if (next_entries[i].valid) begin
                live_ids = live_ids | next_entries[i].b_id;
            end
        end

        if (alloc) begin
            for (int k = 0; k < BR_DEPTH; k++) begin
                if (grant[k]) begin
                    next_entries[k].valid    = 1'b1;
                    next_entries[k].b_id     = grant;
                    next_entries[k].b_mask   = live_ids | grant;
                    next_entries[k].rec_pc   = branch_pc;
                    next_entries[k].rec_mt   = in_mt;       // map before this cycle's rename
                    next_entries[k].fl_head  = in_fl_head;
                    next_entries[k].rob_tail = in_rob_tail;
                end
            end
        end

        // wakeup reaches stored checkpoints too, including one taken this cycle
        if (cdb_valid) begin
            for (int j = 0; j < BR_DEPTH; j++) begin
                if (next_entries[j].valid
                        && (next_entries[j].rec_mt[cdb_arch].phys == cdb_phys)) begin
                    next_entries[j].rec_mt[cdb_arch].ready = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
        end else begin
            entries <= next_entries;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        (br_task != BR_NONE) |-> $onehot(rem_b_id));

endmodule

// ==== src/rename_recovery.sv ====
`timescale 1ns/10ps

module rename_recovery (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  dispatch_valid,
    input  logic                  dispatch_branch,
    input  logic                  dispatch_has_dest,
    input  rename_pkg::arch_idx_t dispatch_dest,
    input  rename_pkg::pc_t       dispatch_pc,
    input  rename_pkg::rob_idx_t  rob_tail,

    input  rename_pkg::br_task_e  br_task,
    input  rename_pkg::b_id_t     rem_b_id,

    input  logic                  cdb_valid,
    input  rename_pkg::arch_idx_t cdb_arch,
    input  rename_pkg::phys_idx_t cdb_phys,

    input  logic                  retire_valid,
    input  rename_pkg::phys_idx_t retire_phys,

    input  rename_pkg::arch_idx_t lookup_arch,

    output rename_pkg::phys_idx_t dispatch_phys,
    output rename_pkg::b_id_t     assigned_b_id,
    output logic                  stall_free,
    output logic                  stall_branch,
    output logic                  recover_valid,
    output rename_pkg::pc_t       recover_pc,
    output rename_pkg::rob_idx_t  recover_rob_tail,
    output rename_pkg::phys_idx_t lookup_phys,
    output logic                  lookup_ready
);

    import rename_pkg::*;

    map_entry_t [ARCH_REG_SZ-1:0] live_mt;
    checkpoint_t                  cp;
    phys_idx_t                    head_phys;
    fl_ptr_t                      fl_head;
    logic                         squash;
    logic                         rename_pop;
    logic                         take_branch;

    // a squash kills whatever dispatches alongside it
    assign rename_pop  = dispatch_valid && dispatch_has_dest && !stall_free && !squash;
    assign take_branch = dispatch_valid && dispatch_branch && !squash;

    assign dispatch_phys    = rename_pop ? head_phys : '0;
    assign recover_valid    = squash;
    assign recover_pc       = cp.rec_pc;
    assign recover_rob_tail = cp.rob_tail;

    free_list u_free_list (
        .clock         (clock),
        .reset         (reset),
        .pop           (rename_pop),
        .push          (retire_valid),
        .push_phys     (retire_phys),
        .restore_valid (squash),
        .restore_head  (cp.fl_head),
        .head_phys     (head_phys),
        .head          (fl_head),
        .empty         (stall_free)
    );

    map_table u_map_table (
        .clock         (clock),
        .reset         (reset),
        .rename_valid  (rename_pop),
        .rename_arch   (dispatch_dest),
        .rename_phys   (head_phys),
        .cdb_valid     (cdb_valid),
        .cdb_arch      (cdb_arch),
        .cdb_phys      (cdb_phys),
        .restore_valid (squash),
        .restore_cp    (cp),
        .lookup_arch   (lookup_arch),
        .lookup_phys   (lookup_phys),
        .lookup_ready  (lookup_ready),
        .mt_out        (live_mt)
    );

    br_stack u_br_stack (
        .clock         (clock),
        .reset         (reset),
        .take_branch   (take_branch),
        .branch_pc     (dispatch_pc),
        .in_mt         (live_mt),
        .in_fl_head    (fl_head),
        .in_rob_tail   (rob_tail),
        .cdb_valid     (cdb_valid),
        .cdb_arch      (cdb_arch),
        .cdb_phys      (cdb_phys),
        .br_task       (br_task),
        .rem_b_id      (rem_b_id),
        .assigned_b_id (assigned_b_id),
        .full          (stall_branch),
        .restore_valid (squash),
        .cp_out        (cp)
    );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clock
);

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

endmodule

// ==== sim/rename_recovery_tb.sv ====
`timescale 1ns/10ps

module rename_recovery_tb;

    import rename_pkg::*;

    localparam int    RESET_CYCLES = 5;
    localparam int    MAX_CYCLES   = 200;  // well past the length of the data file
    localparam string DATA_FILE    = "sim/rename_testdata.txt";

    // first column of each data line
    localparam int OP_IDLE     = 0;
    localparam int OP_DISPATCH = 1;
    localparam int OP_BRANCH   = 2;
    localparam int OP_RESOLVE  = 3;
    localparam int OP_CDB      = 4;
    localparam int OP_RETIRE   = 5;

    logic      clock;
    logic      reset;
    logic      dispatch_valid;
    logic      dispatch_branch;
    logic      dispatch_has_dest;
    arch_idx_t dispatch_dest;
    pc_t       dispatch_pc;
    rob_idx_t  rob_tail;
    br_task_e  br_task;
    b_id_t     rem_b_id;
    logic      cdb_valid;
    arch_idx_t cdb_arch;
    phys_idx_t cdb_phys;
    logic      retire_valid;
    phys_idx_t retire_phys;
    arch_idx_t lookup_arch;

    phys_idx_t dispatch_phys;
    b_id_t     assigned_b_id;
    logic      stall_free;
    logic      stall_branch;
    logic      recover_valid;
    pc_t       recover_pc;
    rob_idx_t  recover_rob_tail;
    phys_idx_t lookup_phys;
    logic      lookup_ready;

    int mismatches;
    int other_errors;
    int line_no;
    int cycles;

    tb_clock u_clock (.clock(clock));

    rename_recovery u_dut (.*);

    task automatic idle_inputs();
        dispatch_valid    = 1'b0;
        dispatch_branch   = 1'b0;
        dispatch_has_dest = 1'b0;
        dispatch_dest     = '0;
        dispatch_pc       = '0;
        rob_tail          = '0;
        br_task           = BR_NONE;
        rem_b_id          = '0;
        cdb_valid         = 1'b0;
        cdb_arch          = '0;
        cdb_phys          = '0;
        retire_valid      = 1'b0;
        retire_phys       = '0;
        lookup_arch       = '0;
    endtask

    task automatic check_phys(input string name, input phys_idx_t got, input phys_idx_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("[FAIL] %s = 0x%h, expected 0x%h at data line %0d", name, got, exp, line_no);
        end
    endtask

    task automatic check_b_id(input string name, input b_id_t got, input b_id_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("[FAIL] %s = 0x%h, expected 0x%h at data line %0d", name, got, exp, line_no);
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("[FAIL] %s = 0x%h, expected 0x%h at data line %0d", name, got, exp, line_no);
        end
    endtask

    task automatic check_rob(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("[FAIL] %s = 0x%h, expected 0x%h at data line %0d", name, got, exp, line_no);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("[FAIL] %s = 0x%h, expected 0x%h at data line %0d", name, got, exp, line_no);
        end
    endtask

    task automatic drive_line(input logic [31:0] op, input logic [31:0] a1,
                              input logic [31:0] a2, input logic [31:0] look);
        idle_inputs();
        lookup_arch = arch_idx_t'(look);
        case (op)
            OP_IDLE: ;
            OP_DISPATCH: begin
                dispatch_valid    = 1'b1;
                dispatch_has_dest = 1'b1;
                dispatch_dest     = arch_idx_t'(a1);
            end
            OP_BRANCH: begin
                dispatch_valid  = 1'b1;
                dispatch_branch = 1'b1;
                dispatch_pc     = a1;
                rob_tail        = rob_idx_t'(a2);
            end
            OP_RESOLVE: begin
                br_task  = br_task_e'(a1[1:0]);
                rem_b_id = b_id_t'(a2);
            end
            OP_CDB: begin
                cdb_valid = 1'b1;
                cdb_arch  = arch_idx_t'(a1);
                cdb_phys  = phys_idx_t'(a2);
            end
            OP_RETIRE: begin
                retire_valid = 1'b1;
                retire_phys  = phys_idx_t'(a1);
            end
            default: begin
                other_errors++;
                $display("unknown opcode %0d at data line %0d", op, line_no);
            end
        endcase
    endtask

    task automatic run_file(input int fd);
        string       line;
        int          n;
        bit          done;
        logic [31:0] op, a1, a2, look;
        logic [31:0] e_phys, e_bid, e_sf, e_sb, e_rv, e_pc, e_rob, e_lphys, e_lrdy, care;
        done = 1'b0;
        while (!done) begin
            if (cycles >= MAX_CYCLES) begin
                other_errors++;
                $display("timeout: data file not finished after %0d cycles", MAX_CYCLES);
                done = 1'b1;
            end else if ($fgets(line, fd) == 0) begin
                done = 1'b1;
            end else begin
                line_no++;
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                op, a1, a2, look, e_phys, e_bid, e_sf, e_sb, e_rv, e_pc,
                                e_rob, e_lphys, e_lrdy, care);
                    if (n != 14) begin
                        other_errors++;
                        $display("data line %0d is malformed, %0d fields read", line_no, n);
                    end else begin
                        @(posedge clock);
                        #1;
                        drive_line(op, a1, a2, look);
                        #2.5;  // just before the next rising edge
                        if (care[0]) check_phys("dispatch_phys", dispatch_phys, e_phys[3:0]);
                        if (care[1]) check_b_id("assigned_b_id", assigned_b_id, e_bid[3:0]);
                        if (care[2]) check_bit("stall_free", stall_free, e_sf[0]);
                        if (care[3]) check_bit("stall_branch", stall_branch, e_sb[0]);
                        if (care[4]) check_bit("recover_valid", recover_valid, e_rv[0]);
                        if (care[5]) check_pc("recover_pc", recover_pc, e_pc);
                        if (care[6]) check_rob("recover_rob_tail", recover_rob_tail, e_rob[3:0]);
                        if (care[7]) check_phys("lookup_phys", lookup_phys, e_lphys[3:0]);
                        if (care[8]) check_bit("lookup_ready", lookup_ready, e_lrdy[0]);
                        cycles++;
                    end
                end
            end
        end
    endtask

    initial begin
        int fd;
        mismatches   = 0;
        other_errors = 0;
        line_no      = 0;
        cycles       = 0;
        idle_inputs();
        reset = 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clock);
        end
        #1;
        reset = 1'b0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open %s", DATA_FILE);
        end else begin
            run_file(fd);
            $fclose(fd);
        end

        $display("errors: %0d value mismatches, %0d other", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
src/rename_pkg.sv
src/free_select.sv
src/free_list.sv
src/map_table.sv
src/br_stack.sv
src/rename_recovery.sv
sim/tb_clock.sv
sim/rename_recovery_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rename_recovery_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qFx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/rename_testdata.txt ====
# op a1 a2 look | dphys bid sf sb rv rec_pc rob lphys lrdy | care (bit 0 dphys .. bit 8 lrdy), all hex
# op 0 idle, 1 dispatch a1=dest, 2 branch a1=pc a2=rob, 3 resolve a1=task a2=id, 4 cdb, 5 retire
0 0 0 0 0 0 0 0 0 00000000 0 0 1 1ff
0 0 0 5 0 0 0 0 0 00000000 0 5 1 1ff
1 1 0 1 8 0 0 0 0 00000000 0 1 1 1ff
1 2 0 1 9 0 0 0 0 00000000 0 8 0 1ff
1 3 0 2 a 0 0 0 0 00000000 0 9 0 1ff
4 1 8 1 0 0 0 0 0 00000000 0 8 0 1ff
0 0 0 1 0 0 0 0 0 00000000 0 8 1 1ff
2 00000100 3 3 0 1 0 0 0 00000000 0 a 0 1ff
1 2 0 2 b 0 0 0 0 00000000 0 9 0 1ff
4 2 9 2 0 0 0 0 0 00000000 0 b 0 1ff
2 00000200 5 0 0 2 0 0 0 00000000 0 0 1 1ff
2 00000300 7 0 0 4 0 0 0 00000000 0 0 1 1ff
2 00000400 9 0 0 8 0 0 0 00000000 0 0 1 1ff
2 00000500 b 0 0 0 0 1 0 00000000 0 0 1 1ff
3 1 2 0 0 0 0 1 0 00000000 0 0 1 1ff
2 00000600 c 0 0 2 0 0 0 00000000 0 0 1 1ff
1 4 0 4 c 0 0 1 0 00000000 0 4 1 1ff
3 2 8 4 0 0 0 1 1 00000400 9 c 0 1ff
0 0 0 4 0 0 0 0 0 00000000 0 4 1 1ff
1 5 0 5 c 0 0 0 0 00000000 0 5 1 1ff
3 2 1 5 0 0 0 0 1 00000100 3 c 0 1ff
0 0 0 2 0 0 0 0 0 00000000 0 9 1 1ff
0 0 0 5 0 0 0 0 0 00000000 0 5 1 1ff
1 6 0 3 b 0 0 0 0 00000000 0 a 0 1ff
2 00000700 1 6 0 1 0 0 0 00000000 0 b 0 1ff
2 00000800 2 6 0 2 0 0 0 00000000 0 b 0 1ff
2 00000900 4 6 0 4 0 0 0 00000000 0 b 0 1ff
3 2 1 0 0 0 0 0 1 00000700 1 0 1 1ff
1 0 0 0 c 0 0 0 0 00000000 0 0 1 1ff
1 1 0 0 d 0 0 0 0 00000000 0 c 0 1ff
1 2 0 1 e 0 0 0 0 00000000 0 d 0 1ff
1 3 0 2 f 0 0 0 0 00000000 0 e 0 1ff
1 4 0 3 0 0 1 0 0 00000000 0 f 0 1ff
1 5 0 4 0 0 1 0 0 00000000 0 4 1 1ff
5 1 0 5 0 0 1 0 0 00000000 0 5 1 1ff
0 0 0 0 0 0 0 0 0 00000000 0 c 0 1ff
1 7 0 7 1 0 0 0 0 00000000 0 7 1 1ff
0 0 0 7 0 0 1 0 0 00000000 0 1 0 1ff
